//--- sim.f
source/seq_isa_pkg.sv
source/seq_cfg_pkg.sv
source/seq_vid_alloc.sv
source/seq_unit_credits.sv
source/seq_hazard_check.sv
source/seq_issue.sv
source/seq_top.sv
sim/seq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module seq_tb -o seq_sim
./obj_dir/seq_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- sim/seq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seq_tb;

  import seq_isa_pkg::*;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_valid_i, req_ready_o, req_vm_i;
  logic req_use_vs1_i, req_use_vs2_i, req_use_vd_i;
  seq_op_e req_op_i;
  vreg_t req_vs1_i, req_vs2_i, req_vd_i;
  logic [7:0] req_vl_i;
  logic issue_valid_o, issue_vm_o, idle_o;
  logic [2:0] issue_id_o;
  seq_op_e issue_op_o;
  seq_unit_e issue_unit_o;
  vreg_t issue_vs1_o, issue_vs2_o, issue_vd_o;
  logic [7:0] issue_vl_o, running_o;
  logic [7:0] issue_hazard_vs1_o, issue_hazard_vs2_o, issue_hazard_vm_o, issue_hazard_vd_o;
  logic [5:0][7:0] unit_done_i;
  logic [7:0][7:0] hazard_table_o;

  seq_top i_dut (.*);

  // 100 ns clock period
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the sequencer state
  ////////////////////////////////////////////////////////////////////////////

  bit [5:0][7:0] run;
  bit [7:0][7:0] tbl;
  bit [31:0] wr_v, rd_v;
  int wr_id [32];
  int rd_id [32];
  int occ [6];
  int depth [6] = '{4, 4, 2, 2, 2, 1};
  int errors, test_err, passed, failed;
  string cur_test;
  logic [31:0] rng = 32'h33b3;
  bit acc_q;
  // Ready as the model predicts it for the request on the port
  bit model_ready;

  function automatic logic [7:0] run_mask();
    logic [7:0] m;
    m = '0;
    for (int u = 0; u < 6; u++) m = m | run[u];
    return m;
  endfunction

  // Queues occupied by an op, a masked op also goes through the mask unit
  function automatic logic [5:0] units_of(int op, bit vm);
    logic [5:0] u;
    u = '0;
    case (op)
      0: u[0] = 1'b1;
      1: u[1] = 1'b1;
      2: u = 6'b100001;
      3: u[2] = 1'b1;
      4: u[3] = 1'b1;
      default: u[4] = 1'b1;
    endcase
    if (!vm) u[5] = 1'b1;
    return u;
  endfunction

  function automatic int prim_unit(int op);
    case (op)
      0: return 0;
      1: return 1;
      2: return 5;
      3: return 2;
      4: return 3;
      default: return 4;
    endcase
  endfunction

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_val(input string what, input int exp, input int act);
    assert (exp == act) else begin
      errors++;
      $display("Fail %s %s expected %0h actual %0h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_table();
    for (int n = 0; n < 8; n++) check_val($sformatf("table row %0d", n),
                                          int'(tbl[n]), int'(hazard_table_o[n]));
    check_val("running_o", int'(run_mask()), int'(running_o));
  endtask

  // The issue strobe must follow each acceptance by exactly one cycle
  always @(posedge clk_i) begin
    if (rst_ni) begin
      assert (issue_valid_o == acc_q) else begin
        errors++;
        $display("Fail %s issue_valid_o expected %0d actual %0d", cur_test, acc_q,
                 issue_valid_o);
      end
      acc_q <= req_valid_i & model_ready;
    end else begin
      acc_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher and unit drivers
  ////////////////////////////////////////////////////////////////////////////

  // Offers one request for one cycle and checks ready, ID and hazards
  task automatic try_send(input int op, input bit vm, input int vs1, input bit u1,
                          input int vs2, input bit u2, input int vd, input bit ud,
                          output bit ok);
    logic [7:0] h1, h2, hm, hd, all;
    logic [7:0] busy;
    logic [5:0] units;
    bit exp_rdy;
    int id;
    h1 = '0;
    h2 = '0;
    hm = '0;
    hd = '0;
    if (u1 && wr_v[vs1]) h1[wr_id[vs1]] = 1'b1;
    if (u2 && wr_v[vs2]) h2[wr_id[vs2]] = 1'b1;
    if (!vm && wr_v[0]) hm[wr_id[0]] = 1'b1;
    if (ud && rd_v[vd]) begin
      h1[rd_id[vd]] = 1'b1;
      h2[rd_id[vd]] = 1'b1;
      hm[rd_id[vd]] = 1'b1;
    end
    if (ud && wr_v[vd]) hd[wr_id[vd]] = 1'b1;
    all = h1 | h2 | hm | hd;
    units = units_of(op, vm);
    busy = run_mask();
    exp_rdy = !(&busy);
    for (int u = 0; u < 6; u++) if (units[u] && occ[u] >= depth[u]) exp_rdy = 1'b0;
    if (!u1 && !u2 && vm && |all) exp_rdy = 1'b0;
    if (op == 5 && |(hd | h1 | h2)) exp_rdy = 1'b0;
    if (op == 6 && |(h1 | h2)) exp_rdy = 1'b0;
    id = 0;
    while (id < 7 && busy[id]) id++;
    model_ready = exp_rdy;
    req_op_i = seq_op_e'(op);
    req_vm_i = vm;
    req_vs1_i = vreg_t'(vs1);
    req_use_vs1_i = u1;
    req_vs2_i = vreg_t'(vs2);
    req_use_vs2_i = u2;
    req_vd_i = vreg_t'(vd);
    req_use_vd_i = ud;
    req_vl_i = 8'(op + vd);
    req_valid_i = 1'b1;
    #5;
    check_val("req_ready_o", int'(exp_rdy), int'(req_ready_o));
    ok = req_ready_o;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    if (ok) begin
      check_val("issue_id_o", id, int'(issue_id_o));
      check_val("issue_op_o", op, int'(issue_op_o));
      check_val("issue_unit_o", prim_unit(op), int'(issue_unit_o));
      check_val("issue_vs1_o", vs1, int'(issue_vs1_o));
      check_val("issue_vs2_o", vs2, int'(issue_vs2_o));
      check_val("issue_vd_o", vd, int'(issue_vd_o));
      check_val("issue_vm_o", int'(vm), int'(issue_vm_o));
      check_val("issue_vl_o", op + vd, int'(issue_vl_o));
      check_val("hazard vs1", int'(h1), int'(issue_hazard_vs1_o));
      check_val("hazard vs2", int'(h2), int'(issue_hazard_vs2_o));
      check_val("hazard vm", int'(hm), int'(issue_hazard_vm_o));
      check_val("hazard vd", int'(hd), int'(issue_hazard_vd_o));
      tbl[id] = all;
      for (int u = 0; u < 6; u++) begin
        if (units[u]) begin
          run[u][id] = 1'b1;
          occ[u]++;
        end
      end
      if (ud) begin
        wr_v[vd] = 1'b1;
        wr_id[vd] = id;
      end
      if (u1) begin
        rd_v[vs1] = 1'b1;
        rd_id[vs1] = id;
      end
      if (u2) begin
        rd_v[vs2] = 1'b1;
        rd_id[vs2] = id;
      end
      if (!vm) begin
        rd_v[0] = 1'b1;
        rd_id[0] = id;
      end
      check_table();
    end
  endtask

  task automatic send(input int op, input bit vm, input int vs1, input bit u1,
                      input int vs2, input bit u2, input int vd, input bit ud);
    bit ok;
    int tries;
    ok = 1'b0;
    tries = 0;
    while (!ok && tries < 20) begin
      try_send(op, vm, vs1, u1, vs2, u2, vd, ud, ok);
      tries++;
    end
    if (!ok) begin
      errors++;
      $display("Timeout in %s: a request was never accepted", cur_test);
    end
  endtask

  // One done pulse, the model retires the ID once no unit holds it
  task automatic finish(input int u, input int id);
    logic [7:0] m;
    unit_done_i[u][id] = 1'b1;
    @(posedge clk_i);
    #1;
    unit_done_i = '0;
    run[u][id] = 1'b0;
    occ[u]--;
    m = run_mask();
    for (int r = 0; r < 32; r++) begin
      if (wr_v[r] && !m[wr_id[r]]) wr_v[r] = 1'b0;
      if (rd_v[r] && !m[rd_id[r]]) rd_v[r] = 1'b0;
    end
    for (int n = 0; n < 8; n++) tbl[n] = tbl[n] & m;
    check_table();
  endtask

  // Completes the lowest running ID in the first unit that still holds it
  task automatic retire_lowest();
    logic [7:0] busy;
    int id;
    int u;
    busy = run_mask();
    if (busy != '0) begin
      id = 0;
      while (!busy[id]) id++;
      u = 0;
      while (!run[u][id]) u++;
      finish(u, id);
    end
  endtask

  // A blocked request is offered again after one more instruction retires
  task automatic send_retiring(input int op, input bit vm, input int vs1, input bit u1,
                               input int vs2, input bit u2, input int vd, input bit ud);
    bit ok;
    int tries;
    ok = 1'b0;
    tries = 0;
    while (!ok && tries < 40) begin
      try_send(op, vm, vs1, u1, vs2, u2, vd, ud, ok);
      if (!ok) retire_lowest();
      tries++;
    end
    if (!ok) begin
      errors++;
      $display("Timeout in %s: a request was never accepted", cur_test);
    end
  endtask

  task automatic drain();
    for (int id = 0; id < 8; id++)
      for (int u = 0; u < 6; u++)
        if (run[u][id]) finish(u, id);
    check_val("idle_o", 1, int'(idle_o));
  endtask

  task automatic expect_block(input int op, input bit vm, input int vs1, input bit u1,
                              input int vs2, input bit u2, input int vd, input bit ud);
    bit ok;
    try_send(op, vm, vs1, u1, vs2, u2, vd, ud, ok);
    if (ok) begin
      errors++;
      $display("Fail %s a request that should stall was accepted", cur_test);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = errors;
  endtask

  task automatic end_test();
    if (errors == test_err) begin
      passed++;
      $display("Pass %s", cur_test);
    end else begin
      failed++;
      $display("Fail %s with %0d errors", cur_test, errors - test_err);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [7:0] busy;
    int id;
    int u;
    req_valid_i = 1'b0;
    req_op_i = OP_ADD;
    req_vm_i = 1'b1;
    req_vs1_i = '0;
    req_vs2_i = '0;
    req_vd_i = '0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    req_use_vd_i = 1'b0;
    req_vl_i = '0;
    unit_done_i = '0;
    cur_test = "reset";
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    start_test("reset");
    check_val("idle_o", 1, int'(idle_o));
    check_table();
    send(0, 1, 2, 1, 2, 0, 1, 1);
    drain();
    end_test();

    start_test("id_alloc");
    for (int i = 0; i < 4; i++) send(0, 1, 20 + i, 1, 0, 0, 8 + i, 1);
    expect_block(0, 1, 24, 1, 0, 0, 12, 1);
    finish(0, 1);
    send(0, 1, 25, 1, 0, 0, 13, 1);
    drain();
    end_test();

    // Each pair puts the earlier ID into the vector of the later one
    start_test("hazards");
    send(0, 1, 1, 1, 2, 1, 3, 1);
    send(0, 1, 3, 1, 2, 0, 9, 1);
    drain();
    send(0, 1, 5, 1, 2, 0, 10, 1);
    send(0, 1, 1, 1, 2, 0, 5, 1);
    drain();
    send(1, 1, 1, 1, 2, 1, 7, 1);
    send(1, 1, 4, 1, 2, 1, 7, 1);
    drain();
    send(0, 1, 1, 1, 2, 0, 0, 1);
    send(0, 0, 1, 1, 2, 0, 11, 1);
    drain();
    end_test();

    start_test("credits");
    send(3, 1, 0, 0, 0, 0, 12, 1);
    send(3, 1, 0, 0, 0, 0, 13, 1);
    expect_block(3, 1, 0, 0, 0, 0, 14, 1);
    finish(2, 0);
    send(3, 1, 0, 0, 0, 0, 14, 1);
    drain();
    send(2, 1, 1, 1, 2, 1, 15, 1);
    expect_block(0, 0, 1, 1, 0, 0, 16, 1);
    finish(5, 0);
    send(0, 0, 1, 1, 0, 0, 16, 1);
    drain();
    end_test();

    start_test("slide_stall");
    send(0, 1, 1, 1, 0, 0, 4, 1);
    expect_block(5, 1, 0, 0, 6, 1, 4, 1);
    finish(0, 0);
    send(5, 1, 0, 0, 6, 1, 4, 1);
    drain();
    end_test();

    // Small register range so that hazards come up often
    start_test("random");
    for (int s = 0; s < 300; s++) begin
      r = next_rand();
      busy = run_mask();
      if (r[1:0] == 2'b00 && |busy) begin
        id = int'(r[4:2]);
        while (!busy[id]) id = (id + 1) % 8;
        u = 0;
        while (!run[u][id]) u++;
        finish(u, id);
      end else begin
        send_retiring(int'(r[4:2]) % 7, r[5], int'(r[8:6]), r[9], int'(r[12:10]), r[13],
                      int'(r[16:14]), r[17]);
      end
    end
    drain();
    end_test();

    $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Guard against a stalled run
  initial begin
    #2000000;
    $display("Timeout: the simulation did not reach its end");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/seq_top.sv
`timescale 1ns/1ps
`default_nettype none

module seq_top #(
  parameter int unsigned NrVInsn                           = seq_cfg_pkg::DefaultNrVInsn,
  parameter int unsigned QueueDepth [seq_isa_pkg::NrUnits] = seq_cfg_pkg::DefaultQueueDepth
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  // Dispatcher side
  input  wire logic                                          req_valid_i,
  output logic                                               req_ready_o,
  input  wire seq_isa_pkg::seq_op_e                          req_op_i,
  input  wire logic                                          req_vm_i,
  input  wire seq_isa_pkg::vreg_t                            req_vs1_i,
  input  wire logic                                          req_use_vs1_i,
  input  wire seq_isa_pkg::vreg_t                            req_vs2_i,
  input  wire logic                                          req_use_vs2_i,
  input  wire seq_isa_pkg::vreg_t                            req_vd_i,
  input  wire logic                                          req_use_vd_i,
  input  wire logic [seq_isa_pkg::VlWidth-1:0]               req_vl_i,
  // Functional unit side
  output logic                                               issue_valid_o,
  output logic      [$clog2(NrVInsn)-1:0]                    issue_id_o,
  output seq_isa_pkg::seq_op_e                               issue_op_o,
  output seq_isa_pkg::seq_unit_e                             issue_unit_o,
  output seq_isa_pkg::vreg_t                                 issue_vs1_o,
  output seq_isa_pkg::vreg_t                                 issue_vs2_o,
  output seq_isa_pkg::vreg_t                                 issue_vd_o,
  output logic                                               issue_vm_o,
  output logic      [seq_isa_pkg::VlWidth-1:0]               issue_vl_o,
  output logic      [NrVInsn-1:0]                            issue_hazard_vs1_o,
  output logic      [NrVInsn-1:0]                            issue_hazard_vs2_o,
  output logic      [NrVInsn-1:0]                            issue_hazard_vm_o,
  output logic      [NrVInsn-1:0]                            issue_hazard_vd_o,
  input  wire logic [seq_isa_pkg::NrUnits-1:0][NrVInsn-1:0]  unit_done_i,
  // Status
  output logic      [NrVInsn-1:0]                            running_o,
  output logic                                               idle_o,
  output logic      [NrVInsn-1:0][NrVInsn-1:0]               hazard_table_o
);

  import seq_isa_pkg::*;

  localparam int unsigned IdW = $clog2(NrVInsn);

  // Check stage results and the accept pulse that closes the loop
  logic [IdW-1:0]     free_id;
  logic               full;
  logic [NrVInsn-1:0] running_next;
  logic [NrUnits-1:0] credit_ok;
  logic [NrVInsn-1:0] haz_vs1, haz_vs2, haz_vm, haz_vd;
  logic               accept;
  logic [NrUnits-1:0] accept_units;

  seq_vid_alloc #(.NrVInsn(NrVInsn)) i_vid_alloc (
    .clk_i, .rst_ni,
    .accept_i       (accept),
    .accept_id_i    (free_id),
    .accept_units_i (accept_units),
    .unit_done_i,
    .free_id_o      (free_id),
    .full_o         (full),
    .running_o,
    .running_next_o (running_next),
    .idle_o
  );

  seq_unit_credits #(.NrVInsn(NrVInsn), .QueueDepth(QueueDepth)) i_unit_credits (
    .clk_i, .rst_ni,
    .accept_i       (accept),
    .accept_units_i (accept_units),
    .unit_done_i,
    .credit_ok_o    (credit_ok)
  );

  seq_hazard_check #(.NrVInsn(NrVInsn)) i_hazard_check (
    .clk_i, .rst_ni,
    .req_vs1_i, .req_use_vs1_i, .req_vs2_i, .req_use_vs2_i,
    .req_vd_i, .req_use_vd_i, .req_vm_i,
    .accept_i       (accept),
    .accept_id_i    (free_id),
    .running_next_i (running_next),
    .haz_vs1_o      (haz_vs1),
    .haz_vs2_o      (haz_vs2),
    .haz_vm_o       (haz_vm),
    .haz_vd_o       (haz_vd)
  );

  seq_issue #(.NrVInsn(NrVInsn)) i_issue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vm_i, .req_vs1_i, .req_vs2_i, .req_vd_i,
    .req_use_vs1_i, .req_use_vs2_i, .req_vl_i,
    .free_id_i      (free_id),
    .full_i         (full),
    .credit_ok_i    (credit_ok),
    .haz_vs1_i      (haz_vs1),
    .haz_vs2_i      (haz_vs2),
    .haz_vm_i       (haz_vm),
    .haz_vd_i       (haz_vd),
    .running_next_i (running_next),
    .req_ready_o,
    .accept_o       (accept),
    .accept_units_o (accept_units),
    .issue_valid_o, .issue_id_o, .issue_op_o, .issue_unit_o,
    .issue_vs1_o, .issue_vs2_o, .issue_vd_o, .issue_vm_o, .issue_vl_o,
    .issue_hazard_vs1_o, .issue_hazard_vs2_o, .issue_hazard_vm_o, .issue_hazard_vd_o,
    .hazard_table_o
  );

endmodule

`default_nettype wire

//--- source/seq_issue.sv
`timescale 1ns/1ps
`default_nettype none

module seq_issue #(
  parameter int unsigned NrVInsn = seq_cfg_pkg::DefaultNrVInsn
) (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                req_valid_i,
  input  wire seq_isa_pkg::seq_op_e                req_op_i,
  input  wire logic                                req_vm_i,
  input  wire seq_isa_pkg::vreg_t                  req_vs1_i,
  input  wire seq_isa_pkg::vreg_t                  req_vs2_i,
  input  wire seq_isa_pkg::vreg_t                  req_vd_i,
  input  wire logic                                req_use_vs1_i,
  input  wire logic                                req_use_vs2_i,
  input  wire logic [seq_isa_pkg::VlWidth-1:0]     req_vl_i,
  input  wire logic [$clog2(NrVInsn)-1:0]          free_id_i,
  input  wire logic                                full_i,
  input  wire logic [seq_isa_pkg::NrUnits-1:0]     credit_ok_i,
  input  wire logic [NrVInsn-1:0]                  haz_vs1_i,
  input  wire logic [NrVInsn-1:0]                  haz_vs2_i,
  input  wire logic [NrVInsn-1:0]                  haz_vm_i,
  input  wire logic [NrVInsn-1:0]                  haz_vd_i,
  input  wire logic [NrVInsn-1:0]                  running_next_i,
  output logic                                     req_ready_o,
  output logic                                     accept_o,
  output logic      [seq_isa_pkg::NrUnits-1:0]     accept_units_o,
  output logic                                     issue_valid_o,
  output logic      [$clog2(NrVInsn)-1:0]          issue_id_o,
  output seq_isa_pkg::seq_op_e                     issue_op_o,
  output seq_isa_pkg::seq_unit_e                   issue_unit_o,
  output seq_isa_pkg::vreg_t                       issue_vs1_o,
  output seq_isa_pkg::vreg_t                       issue_vs2_o,
  output seq_isa_pkg::vreg_t                       issue_vd_o,
  output logic                                     issue_vm_o,
  output logic      [seq_isa_pkg::VlWidth-1:0]     issue_vl_o,
  output logic      [NrVInsn-1:0]                  issue_hazard_vs1_o,
  output logic      [NrVInsn-1:0]                  issue_hazard_vs2_o,
  output logic      [NrVInsn-1:0]                  issue_hazard_vm_o,
  output logic      [NrVInsn-1:0]                  issue_hazard_vd_o,
  output logic      [NrVInsn-1:0][NrVInsn-1:0]     hazard_table_o
);

  import seq_isa_pkg::*;

  localparam int unsigned IdW = $clog2(NrVInsn);

  ////////////////////////////////////////////////////////////////////////////
  // Check stage
  ////////////////////////////////////////////////////////////////////////////

  logic [NrUnits-1:0] targets;
  logic [NrVInsn-1:0] haz_all;
  logic               credits_ok;
  logic               stall;

  always_comb begin
    targets = target_units(req_op_i);
    // Masked instructions also pass through the mask unit
    targets[UNIT_MASK] = targets[UNIT_MASK] | ~req_vm_i;
  end

  // Units that the instruction does not target cannot hold it back
  assign credits_ok = &(~targets | credit_ok_i);
  assign haz_all    = haz_vs1_i | haz_vs2_i | haz_vm_i | haz_vd_i;

  // Without any vector source there is nothing to chain on, so wait for all
  // hazards to clear. Slides move elements across positions and cannot chain
  assign stall = (~req_use_vs1_i & ~req_use_vs2_i & req_vm_i & (|haz_all))
               | ((req_op_i == OP_SLIDEUP) & (|(haz_vd_i | haz_vs1_i | haz_vs2_i)))
               | ((req_op_i == OP_SLIDEDOWN) & (|(haz_vs1_i | haz_vs2_i)));

  assign req_ready_o    = ~full_i & credits_ok & ~stall;
  assign accept_o       = req_valid_i & req_ready_o;
  assign accept_units_o = targets;

  ////////////////////////////////////////////////////////////////////////////
  // Issue stage
  ////////////////////////////////////////////////////////////////////////////

  // One strobe per accepted instruction, the units never push back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= accept_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o         <= free_id_i;
      issue_op_o         <= req_op_i;
      issue_unit_o       <= primary_unit(req_op_i);
      issue_vs1_o        <= req_vs1_i;
      issue_vs2_o        <= req_vs2_i;
      issue_vd_o         <= req_vd_i;
      issue_vm_o         <= req_vm_i;
      issue_vl_o         <= req_vl_i;
      issue_hazard_vs1_o <= haz_vs1_i;
      issue_hazard_vs2_o <= haz_vs2_i;
      issue_hazard_vm_o  <= haz_vm_i;
      issue_hazard_vd_o  <= haz_vd_i;
    end
  end

  // Row n lists the instructions that n waits on
  // Finished instructions leave every row at the edge where they retire
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hazard_table_o <= '0;
    end else begin
      for (int n = 0; n < NrVInsn; n++) begin
        if (accept_o && free_id_i == IdW'(n)) begin
          hazard_table_o[n] <= haz_all & running_next_i;
        end else begin
          hazard_table_o[n] <= hazard_table_o[n] & running_next_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/seq_hazard_check.sv
`timescale 1ns/1ps
`default_nettype none

module seq_hazard_check #(
  parameter int unsigned NrVInsn = seq_cfg_pkg::DefaultNrVInsn
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire seq_isa_pkg::vreg_t            req_vs1_i,
  input  wire logic                          req_use_vs1_i,
  input  wire seq_isa_pkg::vreg_t            req_vs2_i,
  input  wire logic                          req_use_vs2_i,
  input  wire seq_isa_pkg::vreg_t            req_vd_i,
  input  wire logic                          req_use_vd_i,
  input  wire logic                          req_vm_i,
  input  wire logic                          accept_i,
  input  wire logic [$clog2(NrVInsn)-1:0]    accept_id_i,
  input  wire logic [NrVInsn-1:0]            running_next_i,
  output logic      [NrVInsn-1:0]            haz_vs1_o,
  output logic      [NrVInsn-1:0]            haz_vs2_o,
  output logic      [NrVInsn-1:0]            haz_vm_o,
  output logic      [NrVInsn-1:0]            haz_vd_o
);

  import seq_isa_pkg::*;

  localparam int unsigned IdW = $clog2(NrVInsn);

  ////////////////////////////////////////////////////////////////////////////
  // Register access lists
  ////////////////////////////////////////////////////////////////////////////

  // Last reader and last writer of each vector register
  logic [NrVRegs-1:0]  rd_valid_q, rd_valid_d;
  logic [NrVRegs-1:0]  wr_valid_q, wr_valid_d;
  logic [IdW-1:0]      rd_id_q [NrVRegs];
  logic [IdW-1:0]      wr_id_q [NrVRegs];

  // An entry is only meaningful while its instruction survives the next edge
  logic [NrVRegs-1:0]  rd_live;
  logic [NrVRegs-1:0]  wr_live;

  always_comb begin
    for (int r = 0; r < NrVRegs; r++) begin
      rd_live[r] = rd_valid_q[r] & running_next_i[rd_id_q[r]];
      wr_live[r] = wr_valid_q[r] & running_next_i[wr_id_q[r]];
    end
  end

  // Hazard vectors of the request waiting at the dispatcher port
  always_comb begin
    haz_vs1_o = '0;
    haz_vs2_o = '0;
    haz_vm_o  = '0;
    haz_vd_o  = '0;
    // Read after write on each source and on the mask register
    if (req_use_vs1_i && wr_live[req_vs1_i]) haz_vs1_o[wr_id_q[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_live[req_vs2_i]) haz_vs2_o[wr_id_q[req_vs2_i]] = 1'b1;
    if (!req_vm_i && wr_live[VMaskReg]) haz_vm_o[wr_id_q[VMaskReg]] = 1'b1;
    if (req_use_vd_i) begin
      // Write after read holds back every operand path of the new instruction
      if (rd_live[req_vd_i]) begin
        haz_vs1_o[rd_id_q[req_vd_i]] = 1'b1;
        haz_vs2_o[rd_id_q[req_vd_i]] = 1'b1;
        haz_vm_o[rd_id_q[req_vd_i]]  = 1'b1;
      end
      // Write after write on the destination
      if (wr_live[req_vd_i]) haz_vd_o[wr_id_q[req_vd_i]] = 1'b1;
    end
  end

  // Stale entries drop out, then the accepted instruction claims its registers
  always_comb begin
    rd_valid_d = rd_live;
    wr_valid_d = wr_live;
    if (accept_i) begin
      if (req_use_vd_i) wr_valid_d[req_vd_i] = 1'b1;
      if (req_use_vs1_i) rd_valid_d[req_vs1_i] = 1'b1;
      if (req_use_vs2_i) rd_valid_d[req_vs2_i] = 1'b1;
      if (!req_vm_i) rd_valid_d[VMaskReg] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
      wr_valid_q <= '0;
    end else begin
      rd_valid_q <= rd_valid_d;
      wr_valid_q <= wr_valid_d;
    end
  end

  // The IDs only matter where the valid bit is set
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (req_use_vd_i) wr_id_q[req_vd_i] <= accept_id_i;
      if (req_use_vs1_i) rd_id_q[req_vs1_i] <= accept_id_i;
      if (req_use_vs2_i) rd_id_q[req_vs2_i] <= accept_id_i;
      if (!req_vm_i) rd_id_q[VMaskReg] <= accept_id_i;
    end
  end

endmodule

`default_nettype wire

//--- source/seq_unit_credits.sv
`timescale 1ns/1ps
`default_nettype none

module seq_unit_credits #(
  parameter int unsigned NrVInsn                           = seq_cfg_pkg::DefaultNrVInsn,
  parameter int unsigned QueueDepth [seq_isa_pkg::NrUnits] = seq_cfg_pkg::DefaultQueueDepth
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          accept_i,
  input  wire logic [seq_isa_pkg::NrUnits-1:0]               accept_units_i,
  input  wire logic [seq_isa_pkg::NrUnits-1:0][NrVInsn-1:0]  unit_done_i,
  output logic      [seq_isa_pkg::NrUnits-1:0]               credit_ok_o
);

  import seq_isa_pkg::*;
  import seq_cfg_pkg::*;

  // All counters share one width, sized for the deepest queue
  localparam int unsigned CntW = $clog2(MaxQueueDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy counters
  ////////////////////////////////////////////////////////////////////////////

  logic [NrUnits-1:0][CntW-1:0] cnt_q;
  logic [NrUnits-1:0]           cnt_up;
  logic [NrUnits-1:0]           cnt_down;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    // An accepted instruction takes a queue slot in each target unit
    assign cnt_up[u] = accept_i & accept_units_i[u];
    // A unit finishes at most one instruction per cycle
    assign cnt_down[u] = |unit_done_i[u];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + CntW'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - CntW'(1);
      end
    end

    // Room is left while the count is below the depth of that queue
    assign credit_ok_o[u] = cnt_q[u] < CntW'(QueueDepth[u]);
  end

endmodule

`default_nettype wire

//--- source/seq_vid_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module seq_vid_alloc #(
  parameter int unsigned NrVInsn = seq_cfg_pkg::DefaultNrVInsn
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          accept_i,
  input  wire logic [$clog2(NrVInsn)-1:0]                    accept_id_i,
  input  wire logic [seq_isa_pkg::NrUnits-1:0]               accept_units_i,
  input  wire logic [seq_isa_pkg::NrUnits-1:0][NrVInsn-1:0]  unit_done_i,
  output logic      [$clog2(NrVInsn)-1:0]                    free_id_o,
  output logic                                               full_o,
  output logic      [NrVInsn-1:0]                            running_o,
  output logic      [NrVInsn-1:0]                            running_next_o,
  output logic                                               idle_o
);

  import seq_isa_pkg::*;

  localparam int unsigned IdW = $clog2(NrVInsn);

  // Bit [u][i] is set while instruction i still occupies unit u
  logic [NrUnits-1:0][NrVInsn-1:0] run_d, run_q;

  always_comb begin
    run_d          = run_q;
    running_next_o = '0;
    for (int u = 0; u < NrUnits; u++) begin
      // Completion clears the entry of that unit only
      run_d[u] = run_q[u] & ~unit_done_i[u];
      if (accept_i && accept_units_i[u]) run_d[u][accept_id_i] = 1'b1;
      running_next_o = running_next_o | run_d[u];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else begin
      run_q <= run_d;
    end
  end

  // An instruction runs as long as any of its units has not finished it
  always_comb begin
    running_o = '0;
    for (int u = 0; u < NrUnits; u++) running_o = running_o | run_q[u];
  end

  // Lowest free ID, the downward scan leaves the smallest index
  always_comb begin
    free_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) free_id_o = IdW'(i);
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

//--- source/seq_cfg_pkg.sv
`default_nettype none

package seq_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizing of the sequencer
  ////////////////////////////////////////////////////////////////////////////

  // Number of instructions that can be in flight at the same time
  localparam int unsigned DefaultNrVInsn = 8;

  // Instruction queue depth of each unit, indexed by seq_unit_e
  // Order is ALU, MFPU, load, store, slide, mask
  localparam int unsigned DefaultQueueDepth [seq_isa_pkg::NrUnits] = '{
    4,
    4,
    2,
    2,
    2,
    1
  };

  // Largest depth above, this sizes the occupancy counters
  localparam int unsigned MaxQueueDepth = 4;

endpackage

`default_nettype wire

//--- source/seq_isa_pkg.sv
`default_nettype none

package seq_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operations and functional units
  ////////////////////////////////////////////////////////////////////////////

  // Vector operations that the dispatcher can hand to the sequencer
  typedef enum logic [2:0] {
    OP_ADD,
    OP_MUL,
    OP_MASK_CMP,
    OP_LOAD,
    OP_STORE,
    OP_SLIDEUP,
    OP_SLIDEDOWN
  } seq_op_e;

  // Functional units, the value is also the bit index in a unit set
  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_MFPU,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE,
    UNIT_MASK
  } seq_unit_e;

  localparam int unsigned NrUnits = 6;

  // Vector register file, v0 doubles as the mask source
  localparam int unsigned NrVRegs  = 32;
  localparam int unsigned VMaskReg = 0;
  typedef logic [4:0] vreg_t;

  // Width of the vector length field carried with each instruction
  localparam int unsigned VlWidth = 8;

  // Unit that executes the operation
  function automatic seq_unit_e primary_unit(seq_op_e op);
    unique case (op)
      OP_ADD:                    primary_unit = UNIT_ALU;
      OP_MUL:                    primary_unit = UNIT_MFPU;
      OP_MASK_CMP:               primary_unit = UNIT_MASK;
      OP_LOAD:                   primary_unit = UNIT_LOAD;
      OP_STORE:                  primary_unit = UNIT_STORE;
      OP_SLIDEUP, OP_SLIDEDOWN:  primary_unit = UNIT_SLIDE;
      default:                   primary_unit = UNIT_ALU;
    endcase
  endfunction

  // Set of units whose instruction queues the operation occupies
  function automatic logic [NrUnits-1:0] target_units(seq_op_e op);
    logic [NrUnits-1:0] units;
    units = '0;
    units[primary_unit(op)] = 1'b1;
    // Mask compares are computed in the ALU and packed by the mask unit
    if (op == OP_MASK_CMP) units[UNIT_ALU] = 1'b1;
    return units;
  endfunction

endpackage

`default_nettype wire
